// File: rtl/tcdm_pkg.sv
// Group sizes and the word address type shared by every block of the TCDM interconnect
package tcdm_pkg;

  // Initiators and banks
  localparam int unsigned NumIni       = 4;
  localparam int unsigned NumBanks     = 4;
  localparam int unsigned IniIdxWidth  = 2;
  localparam int unsigned BankIdxWidth = 2;

  // 64 words per bank
  localparam int unsigned RowWidth     = 6;
  localparam int unsigned AddrWidth    = RowWidth + BankIdxWidth;

  // One word per access, byte enables per lane
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = DataWidth / 8;

  // Word interleaved, so the low bits pick the bank
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    struct packed {
      logic [RowWidth-1:0]     row;
      logic [BankIdxWidth-1:0] bank;
    } split;
  } tcdm_addr_u;

endpackage : tcdm_pkg

// File: rtl/ini_port.sv
// Initiator gate: blocks new requests while a response is pending and picks the target bank
module ini_port (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               req_valid_i,
  input  logic [tcdm_pkg::AddrWidth-1:0]     req_addr_i,
  input  logic                               gnt_i,
  input  logic                               resp_valid_i,
  input  logic                               resp_ready_i,
  output logic                               masked_valid_o,
  output logic [tcdm_pkg::BankIdxWidth-1:0]  bank_sel_o,
  output logic                               req_ready_o
);

  import tcdm_pkg::*;

  tcdm_addr_u addr;
  logic       outstanding_q;
  logic       req_fire;
  logic       resp_fire;

  assign addr       = req_addr_i;
  assign bank_sel_o = addr.split.bank;

  // One request in flight per initiator
  assign masked_valid_o = req_valid_i & ~outstanding_q;
  assign req_ready_o    = gnt_i;

  assign req_fire  = req_valid_i & gnt_i;
  assign resp_fire = resp_valid_i & resp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (req_fire) begin
      outstanding_q <= 1'b1;
    end else if (resp_fire) begin
      outstanding_q <= 1'b0;
    end
  end

  // A response only ever comes back for a request this port issued
  assert property (@(posedge clk_i) disable iff (!rst_n_i) resp_valid_i |-> outstanding_q)
    else $error("response seen at an initiator with nothing outstanding");

endmodule : ini_port

// File: rtl/bank_arbiter.sv
// Per-bank round-robin arbiter that grants one requesting initiator when the bank can accept
module bank_arbiter (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [tcdm_pkg::NumIni-1:0]       req_i,
  input  logic                              bank_ready_i,
  output logic [tcdm_pkg::NumIni-1:0]       gnt_o,
  output logic [tcdm_pkg::IniIdxWidth-1:0]  gnt_idx_o,
  output logic                              valid_o
);

  import tcdm_pkg::*;

  logic [IniIdxWidth-1:0] ptr_q;
  logic [IniIdxWidth-1:0] cand;
  logic                   found;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    gnt_idx_o = ptr_q;
    found     = 1'b0;
    cand      = ptr_q;
    for (int i = 0; i < NumIni; i++) begin
      cand = ptr_q + IniIdxWidth'(i);
      if (!found && req_i[cand]) begin
        found     = 1'b1;
        gnt_idx_o = cand;
      end
    end
  end

  assign valid_o = found & bank_ready_i;
  assign gnt_o   = valid_o ? (NumIni'(1) << gnt_idx_o) : '0;

  // Winner gets lowest priority next round
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (valid_o) begin
      ptr_q <= gnt_idx_o + 1'b1;
    end
  end

  // Exactly one requester wins whenever the bank is ready and anyone asks
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0) &&
    ((gnt_o != '0) == (bank_ready_i && (req_i != '0))))
    else $error("bank grant is not one-hot, goes to an idle initiator or is missing");

endmodule : bank_arbiter

// File: rtl/tcdm_bank.sv
// Single-port word bank with byte enables and a held response register
module tcdm_bank (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              req_valid_i,
  input  logic [tcdm_pkg::IniIdxWidth-1:0]  req_ini_i,
  input  logic [tcdm_pkg::AddrWidth-1:0]    req_addr_i,
  input  logic                              req_wen_i,
  input  logic [tcdm_pkg::DataWidth-1:0]    req_wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]      req_be_i,
  input  logic                              resp_ready_i,
  output logic                              ready_o,
  output logic                              resp_valid_o,
  output logic [tcdm_pkg::IniIdxWidth-1:0]  resp_ini_o,
  output logic [tcdm_pkg::DataWidth-1:0]    resp_rdata_o
);

  import tcdm_pkg::*;

  logic [DataWidth-1:0]   mem [2**RowWidth];
  tcdm_addr_u             addr;
  logic [RowWidth-1:0]    row;
  logic                   req_fire;
  logic                   resp_valid_q;
  logic [IniIdxWidth-1:0] resp_ini_q;
  logic [DataWidth-1:0]   resp_rdata_q;

  assign addr = req_addr_i;
  assign row  = addr.split.row;

  // Free slot, or the held response leaves this cycle
  assign ready_o  = ~resp_valid_q | resp_ready_i;
  assign req_fire = req_valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (req_fire && req_wen_i) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (req_be_i[b]) begin
          mem[row][8*b +: 8] <= req_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Reads see the word before this edge's write; writes answer with zero
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_ini_q   <= req_ini_i;
      resp_rdata_q <= req_wen_i ? '0 : mem[row];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_ini_o   = resp_ini_q;
  assign resp_rdata_o = resp_rdata_q;

  // Arbiter must respect back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_n_i) req_valid_i |-> ready_o)
    else $error("request presented to a bank that is not ready");

endmodule : tcdm_bank

// File: rtl/resp_xbar.sv
// Response crossbar: steers each held bank response to the initiator index it carries
module resp_xbar (
  input  logic [tcdm_pkg::NumBanks-1:0]                             bank_valid_i,
  input  logic [tcdm_pkg::NumBanks-1:0][tcdm_pkg::IniIdxWidth-1:0]  bank_ini_i,
  input  logic [tcdm_pkg::NumBanks-1:0][tcdm_pkg::DataWidth-1:0]    bank_rdata_i,
  input  logic [tcdm_pkg::NumIni-1:0]                               resp_ready_i,
  output logic [tcdm_pkg::NumIni-1:0]                               resp_valid_o,
  output logic [tcdm_pkg::NumIni-1:0][tcdm_pkg::DataWidth-1:0]      resp_rdata_o,
  output logic [tcdm_pkg::NumBanks-1:0]                             bank_ready_o
);

  import tcdm_pkg::*;

  logic [NumIni-1:0][NumBanks-1:0] match;

  for (genvar i = 0; i < NumIni; i++) begin : gen_ini
    for (genvar b = 0; b < NumBanks; b++) begin : gen_match
      assign match[i][b] = bank_valid_i[b] && (bank_ini_i[b] == IniIdxWidth'(i));
    end

    assign resp_valid_o[i] = |match[i];

    always_comb begin
      resp_rdata_o[i] = '0;
      for (int b = 0; b < NumBanks; b++) begin
        if (match[i][b]) begin
          resp_rdata_o[i] = resp_rdata_o[i] | bank_rdata_i[b];
        end
      end
    end

    // One outstanding request per initiator, so one bank at most
    always_comb begin
      assert final ($onehot0(match[i]))
        else $error("initiator %0d matched by more than one bank", i);
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank_ready
    assign bank_ready_o[b] = resp_ready_i[bank_ini_i[b]];
  end

endmodule : resp_xbar

// File: rtl/tcdm_group.sv
// Group top: four initiator ports sharing four interleaved banks through per-bank arbiters
module tcdm_group (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [tcdm_pkg::NumIni-1:0]                           req_valid_i,
  input  logic [tcdm_pkg::NumIni-1:0][tcdm_pkg::AddrWidth-1:0]  req_addr_i,
  input  logic [tcdm_pkg::NumIni-1:0]                           req_wen_i,
  input  logic [tcdm_pkg::NumIni-1:0][tcdm_pkg::DataWidth-1:0]  req_wdata_i,
  input  logic [tcdm_pkg::NumIni-1:0][tcdm_pkg::BeWidth-1:0]    req_be_i,
  input  logic [tcdm_pkg::NumIni-1:0]                           resp_ready_i,
  output logic [tcdm_pkg::NumIni-1:0]                           req_ready_o,
  output logic [tcdm_pkg::NumIni-1:0]                           resp_valid_o,
  output logic [tcdm_pkg::NumIni-1:0][tcdm_pkg::DataWidth-1:0]  resp_rdata_o
);

  import tcdm_pkg::*;

  // Initiator side
  logic [NumIni-1:0]                   masked_valid;
  logic [NumIni-1:0][BankIdxWidth-1:0] bank_sel;
  logic [NumIni-1:0]                   ini_gnt;

  // Bank side
  logic [NumBanks-1:0][NumIni-1:0]      arb_req;
  logic [NumBanks-1:0][NumIni-1:0]      arb_gnt;
  logic [NumBanks-1:0][IniIdxWidth-1:0] arb_idx;
  logic [NumBanks-1:0]                  arb_valid;
  logic [NumBanks-1:0]                  bank_ready;
  logic [NumBanks-1:0]                  bank_resp_valid;
  logic [NumBanks-1:0][IniIdxWidth-1:0] bank_resp_ini;
  logic [NumBanks-1:0][DataWidth-1:0]   bank_resp_rdata;
  logic [NumBanks-1:0]                  bank_resp_ready;

  for (genvar i = 0; i < NumIni; i++) begin : gen_ini
    // Grant comes from whichever arbiter this initiator targets
    assign ini_gnt[i] = arb_gnt[bank_sel[i]][i];

    ini_port i_ini_port (
      .clk_i         (clk_i          ),
      .rst_n_i       (rst_n_i        ),
      .req_valid_i   (req_valid_i[i] ),
      .req_addr_i    (req_addr_i[i]  ),
      .gnt_i         (ini_gnt[i]     ),
      .resp_valid_i  (resp_valid_o[i]),
      .resp_ready_i  (resp_ready_i[i]),
      .masked_valid_o(masked_valid[i]),
      .bank_sel_o    (bank_sel[i]    ),
      .req_ready_o   (req_ready_o[i] )
    );
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    for (genvar i = 0; i < NumIni; i++) begin : gen_req
      assign arb_req[b][i] = masked_valid[i] && (bank_sel[i] == BankIdxWidth'(b));
    end

    bank_arbiter i_bank_arbiter (
      .clk_i       (clk_i        ),
      .rst_n_i     (rst_n_i      ),
      .req_i       (arb_req[b]   ),
      .bank_ready_i(bank_ready[b]),
      .gnt_o       (arb_gnt[b]   ),
      .gnt_idx_o   (arb_idx[b]   ),
      .valid_o     (arb_valid[b] )
    );

    tcdm_bank i_tcdm_bank (
      .clk_i       (clk_i                     ),
      .rst_n_i     (rst_n_i                   ),
      .req_valid_i (arb_valid[b]              ),
      .req_ini_i   (arb_idx[b]                ),
      .req_addr_i  (req_addr_i[arb_idx[b]]    ),
      .req_wen_i   (req_wen_i[arb_idx[b]]     ),
      .req_wdata_i (req_wdata_i[arb_idx[b]]   ),
      .req_be_i    (req_be_i[arb_idx[b]]      ),
      .resp_ready_i(bank_resp_ready[b]        ),
      .ready_o     (bank_ready[b]             ),
      .resp_valid_o(bank_resp_valid[b]        ),
      .resp_ini_o  (bank_resp_ini[b]          ),
      .resp_rdata_o(bank_resp_rdata[b]        )
    );
  end

  resp_xbar i_resp_xbar (
    .bank_valid_i(bank_resp_valid),
    .bank_ini_i  (bank_resp_ini  ),
    .bank_rdata_i(bank_resp_rdata),
    .resp_ready_i(resp_ready_i   ),
    .resp_valid_o(resp_valid_o   ),
    .resp_rdata_o(resp_rdata_o   ),
    .bank_ready_o(bank_resp_ready)
  );

endmodule : tcdm_group

// File: test/tcdm_group_tb.sv
// Table-driven testbench that checks the TCDM group against a reference memory model
module tcdm_group_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_pkg::*;

  localparam int NumSteps    = 10;
  localparam int StepTimeout = 40;

  // Step modes
  localparam int ModePlain     = 0;
  localparam int ModeSameCycle = 1;
  localparam int ModeHold      = 2;

  logic                                clk_i;
  logic                                rst_n_i;
  logic [NumIni-1:0]                   req_valid_i;
  logic [NumIni-1:0][AddrWidth-1:0]    req_addr_i;
  logic [NumIni-1:0]                   req_wen_i;
  logic [NumIni-1:0][DataWidth-1:0]    req_wdata_i;
  logic [NumIni-1:0][BeWidth-1:0]      req_be_i;
  logic [NumIni-1:0]                   resp_ready_i;
  logic [NumIni-1:0]                   req_ready_o;
  logic [NumIni-1:0]                   resp_valid_o;
  logic [NumIni-1:0][DataWidth-1:0]    resp_rdata_o;

  // Step table, one request slot per initiator
  int                   t_mode  [NumSteps];
  logic [NumIni-1:0]    t_stall [NumSteps];
  logic [NumIni-1:0]    t_valid [NumSteps];
  logic [NumIni-1:0]    t_wen   [NumSteps];
  logic [AddrWidth-1:0] t_addr  [NumSteps][NumIni];
  logic [DataWidth-1:0] t_wdata [NumSteps][NumIni];
  logic [BeWidth-1:0]   t_be    [NumSteps][NumIni];

  // Model memory, indexed by the flat word address
  logic [DataWidth-1:0] ref_mem [2**AddrWidth];

  int seed;
  int checks;
  int errors;
  int timeouts;

  tcdm_group dut_i (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_valid_i (req_valid_i ),
    .req_addr_i  (req_addr_i  ),
    .req_wen_i   (req_wen_i   ),
    .req_wdata_i (req_wdata_i ),
    .req_be_i    (req_be_i    ),
    .resp_ready_i(resp_ready_i),
    .req_ready_o (req_ready_o ),
    .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic check_eq(input string sig, input logic [DataWidth-1:0] got,
                          input logic [DataWidth-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR t=%0t %s got=%h exp=%h", $time, sig, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Failure at t=%0t: %s", $time, what);
    end
  endtask

  task automatic write_ref(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] wdata,
                           input logic [BeWidth-1:0] be);
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        ref_mem[addr][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic add_req(input int s, input int i, input logic wen,
                         input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] wdata,
                         input logic [BeWidth-1:0] be);
    t_valid[s][i] = 1'b1;
    t_wen[s][i]   = wen;
    t_addr[s][i]  = addr;
    t_wdata[s][i] = wdata;
    t_be[s][i]    = be;
  endtask

  task automatic build_table();
    for (int s = 0; s < NumSteps; s++) begin
      t_mode[s]  = ModePlain;
      t_stall[s] = '0;
      t_valid[s] = '0;
      t_wen[s]   = '0;
      for (int i = 0; i < NumIni; i++) begin
        t_addr[s][i]  = '0;
        t_wdata[s][i] = '0;
        t_be[s][i]    = '0;
      end
    end
    // Single initiator write, read back, then byte merges
    add_req(0, 0, 1'b1, 8'h10, 32'hDEAD_BEEF, 4'hF);
    add_req(1, 0, 1'b0, 8'h10, 32'h0, 4'hF);
    add_req(2, 1, 1'b1, 8'h10, 32'h0000_1234, 4'b0011);
    add_req(3, 2, 1'b1, 8'h10, 32'hA5FF_FFFF, 4'b1000);
    add_req(4, 3, 1'b0, 8'h10, 32'h0, 4'hF);
    // Four distinct banks in one cycle
    t_mode[5] = ModeSameCycle;
    add_req(5, 0, 1'b1, 8'h21, 32'h1111_0001, 4'hF);
    add_req(5, 1, 1'b1, 8'h22, 32'h2222_0002, 4'hF);
    add_req(5, 2, 1'b1, 8'h23, 32'h3333_0003, 4'hF);
    add_req(5, 3, 1'b1, 8'h24, 32'h4444_0004, 4'hF);
    t_mode[6] = ModeSameCycle;
    add_req(6, 0, 1'b0, 8'h22, 32'h0, 4'hF);
    add_req(6, 1, 1'b0, 8'h23, 32'h0, 4'hF);
    add_req(6, 2, 1'b0, 8'h24, 32'h0, 4'hF);
    add_req(6, 3, 1'b0, 8'h21, 32'h0, 4'hF);
    // Everyone on bank 0, requests held high
    t_mode[7] = ModeHold;
    add_req(7, 0, 1'b1, 8'h30, 32'hC0DE_0000, 4'hF);
    add_req(7, 1, 1'b1, 8'h34, 32'hC0DE_0001, 4'hF);
    add_req(7, 2, 1'b1, 8'h38, 32'hC0DE_0002, 4'hF);
    add_req(7, 3, 1'b1, 8'h3C, 32'hC0DE_0003, 4'hF);
    t_mode[8] = ModeHold;
    add_req(8, 0, 1'b0, 8'h3C, 32'h0, 4'hF);
    add_req(8, 1, 1'b0, 8'h38, 32'h0, 4'hF);
    add_req(8, 2, 1'b0, 8'h34, 32'h0, 4'hF);
    add_req(8, 3, 1'b0, 8'h30, 32'h0, 4'hF);
    // Initiator 0 stalls its response while the others use other banks
    t_stall[9] = 4'b0001;
    add_req(9, 0, 1'b0, 8'h30, 32'h0, 4'hF);
    add_req(9, 1, 1'b0, 8'h21, 32'h0, 4'hF);
    add_req(9, 2, 1'b0, 8'h22, 32'h0, 4'hF);
    add_req(9, 3, 1'b0, 8'h23, 32'h0, 4'hF);
  endtask

  task automatic run_step(input int s);
    logic [NumIni-1:0]    valid_now;
    logic [NumIni-1:0]    ready_now;
    logic [NumIni-1:0]    waiting;
    logic [NumIni-1:0]    drop;
    logic [DataWidth-1:0] exp_rdata [NumIni];
    int                   acc_cnt   [NumIni];
    int                   done_cyc  [NumIni];
    int                   stall_cnt [NumIni];
    int                   total_acc;
    int                   cyc;
    valid_now = t_valid[s];
    ready_now = ~t_stall[s];
    waiting   = '0;
    total_acc = 0;
    cyc       = 0;
    for (int i = 0; i < NumIni; i++) begin
      exp_rdata[i] = '0;
      acc_cnt[i]   = 0;
      done_cyc[i]  = -1;
      stall_cnt[i] = 2 + ($unsigned($random(seed)) % 8);
    end
    @(posedge clk_i);
    req_valid_i  <= valid_now;
    req_wen_i    <= t_wen[s];
    resp_ready_i <= ready_now;
    for (int i = 0; i < NumIni; i++) begin
      req_addr_i[i]  <= t_addr[s][i];
      req_wdata_i[i] <= t_wdata[s][i];
      req_be_i[i]    <= t_be[s][i];
    end
    do begin
      @(negedge clk_i);
      drop = '0;
      if (t_mode[s] == ModeSameCycle && cyc == 0) begin
        check_eq("req_ready_o", req_ready_o, t_valid[s]);
      end
      for (int i = 0; i < NumIni; i++) begin
        if (waiting[i]) begin
          check_eq($sformatf("resp_valid_o[%0d]", i), resp_valid_o[i], 1);
          check_eq($sformatf("resp_rdata_o[%0d]", i), resp_rdata_o[i], exp_rdata[i]);
          check_eq($sformatf("req_ready_o[%0d]", i), req_ready_o[i], 0);
          if (ready_now[i]) begin
            waiting[i]  = 1'b0;
            done_cyc[i] = cyc;
            if (t_stall[s][i]) drop[i] = 1'b1;
          end else if (stall_cnt[i] > 0) begin
            stall_cnt[i]--;
          end else begin
            ready_now[i] = 1'b1;
          end
        end else begin
          check_eq($sformatf("resp_valid_o[%0d]", i), resp_valid_o[i], 0);
          if (valid_now[i] && req_ready_o[i]) begin
            acc_cnt[i]++;
            total_acc++;
            // Read sees the word before this edge's write
            exp_rdata[i] = req_wen_i[i] ? '0 : ref_mem[req_addr_i[i]];
            if (req_wen_i[i]) write_ref(req_addr_i[i], req_wdata_i[i], req_be_i[i]);
            waiting[i] = 1'b1;
            if (t_mode[s] != ModeHold && !t_stall[s][i]) drop[i] = 1'b1;
          end
        end
      end
      if (t_mode[s] == ModeHold && total_acc >= NumIni) drop = '1;
      valid_now = valid_now & ~drop;
      cyc++;
      @(posedge clk_i);
      req_valid_i  <= valid_now;
      resp_ready_i <= ready_now;
    end while ((valid_now != '0 || waiting != '0) && cyc < StepTimeout);

    if (valid_now != '0 || waiting != '0) begin
      timeouts++;
      $display("Timeout: step %0d did not finish within %0d cycles", s, StepTimeout);
    end else begin
      for (int i = 0; i < NumIni; i++) begin
        if (t_valid[s][i]) begin
          check_true(acc_cnt[i] == 1, $sformatf("step %0d: initiator %0d accepted %0d times",
                                                 s, i, acc_cnt[i]));
        end
        for (int j = 0; j < NumIni; j++) begin
          if (t_stall[s][i] && t_valid[s][j] && !t_stall[s][j]) begin
            check_true(done_cyc[j] < done_cyc[i],
                       $sformatf("step %0d: initiator %0d waited on stalled initiator %0d",
                                 s, j, i));
          end
        end
      end
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = '0;
    req_addr_i   = '0;
    req_wen_i    = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = '1;
    seed         = 80499;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    build_table();

    for (int c = 0; c < 8; c++) begin
      @(negedge clk_i);
      check_eq("req_ready_o", req_ready_o, 0);
      check_eq("resp_valid_o", resp_valid_o, 0);
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_eq("req_ready_o", req_ready_o, 0);
    check_eq("resp_valid_o", resp_valid_o, 0);

    for (int s = 0; s < NumSteps && timeouts == 0; s++) begin
      run_step(s);
    end

    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tcdm_group_tb

// File: filelist.f
rtl/tcdm_pkg.sv
rtl/ini_port.sv
rtl/bank_arbiter.sv
rtl/tcdm_bank.sv
rtl/resp_xbar.sv
rtl/tcdm_group.sv
test/tcdm_group_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the TCDM group testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tcdm_group_tb -f filelist.f

./obj_dir/Vtcdm_group_tb | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
